// File: include/core_config.svh
// Build-time sizing for the integer core
// CORE_FETCH_DEPTH must be at least 2 and equals the source's initial credits
// CORE_RET_CREDITS is the number of retire records the sink can absorb at reset

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data and PC width
`define CORE_XLEN 32

// Architectural registers, x0 included
`define CORE_REG_COUNT 32

// Instruction buffer entries
`define CORE_FETCH_DEPTH 4

// Retire credits held by the core after reset
`define CORE_RET_CREDITS 2

`endif

// File: hw/core_pkg.sv
// Shared types of the integer core
// Only the OP and OP-IMM major opcodes are given names here
// Instruction field widths are fixed by the RV32I encoding

`include "core_config.svh"

package core_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLT  = 4'd5,
        SLTU = 4'd6
    } alu_op_e;

    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // Register-immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Same 32 bits, read as R or I depending on opcode
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_word_u;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        instr_word_u           word;
    } fetch_req_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        reg_idx_t              rs1;
        reg_idx_t              rs2;
        reg_idx_t              rd;
        logic                  use_imm;
        logic [`CORE_XLEN-1:0] imm;
        alu_op_e               alu_op;
        logic                  illegal;
    } uop_t;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        reg_idx_t              rd;
        logic [`CORE_XLEN-1:0] value;
        logic                  illegal;
    } retire_t;

endpackage

// File: hw/fetch_decode.sv
// Input side of the core: credit-counted instruction buffer and decoder
// The source must hold a credit for every valid cycle on fetch_in
// One credit is returned per consumed entry, one cycle after uop_take
// Unsupported encodings become illegal uops with rd forced to x0

`timescale 1ns/1ps

`include "core_config.svh"

module fetch_decode import core_pkg::*; (
    input  logic       clk_g,
    input  logic       rst_n,
    input  fetch_req_t fetch_in,
    output logic       fetch_credit,
    output uop_t       uop,
    output logic       uop_valid,
    input  logic       uop_take
);

    localparam int PTR_W = $clog2(`CORE_FETCH_DEPTH);
    localparam int CNT_W = $clog2(`CORE_FETCH_DEPTH + 1);

    logic [`CORE_XLEN-1:0] buf_pc   [`CORE_FETCH_DEPTH];
    instr_word_u           buf_word [`CORE_FETCH_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    instr_word_u      head;

    assign uop_valid = (count != '0);
    assign pop       = uop_take & uop_valid;
    assign head      = buf_word[rd_ptr];

    // Buffer storage
    always_ff @(posedge clk_g) begin
        if (fetch_in.valid) begin
            buf_pc[wr_ptr]   <= fetch_in.pc;
            buf_word[wr_ptr] <= fetch_in.word;
        end
    end

    // Pointers, occupancy and the credit pulse
    always_ff @(posedge clk_g or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            fetch_credit <= 1'b0;
        end else begin
            if (fetch_in.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(`CORE_FETCH_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`CORE_FETCH_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count        <= count + CNT_W'(fetch_in.valid) - CNT_W'(pop);
            fetch_credit <= pop;
        end
    end

    // Decode of the head entry
    always_comb begin
        uop         = '0;
        uop.pc      = buf_pc[rd_ptr];
        uop.alu_op  = ADD;
        uop.illegal = 1'b1;

        if (head.i.opcode == OP_IMM) begin
            uop.rs1     = head.i.rs1;
            uop.rd      = head.i.rd;
            uop.use_imm = 1'b1;
            uop.imm     = {{(`CORE_XLEN - 12){head.i.imm12[11]}}, head.i.imm12};
            uop.illegal = 1'b0;
            case (head.i.funct3)
                3'b000:  uop.alu_op = ADD;
                3'b010:  uop.alu_op = SLT;
                3'b011:  uop.alu_op = SLTU;
                3'b100:  uop.alu_op = XOR;
                3'b110:  uop.alu_op = OR;
                3'b111:  uop.alu_op = AND;
                // Shifts are not supported
                default: uop.illegal = 1'b1;
            endcase
        end else if (head.r.opcode == OP) begin
            uop.rs1     = head.r.rs1;
            uop.rs2     = head.r.rs2;
            uop.rd      = head.r.rd;
            uop.illegal = 1'b0;
            case ({head.r.funct7, head.r.funct3})
                10'b0000000_000: uop.alu_op = ADD;
                10'b0100000_000: uop.alu_op = SUB;
                10'b0000000_010: uop.alu_op = SLT;
                10'b0000000_011: uop.alu_op = SLTU;
                10'b0000000_100: uop.alu_op = XOR;
                10'b0000000_110: uop.alu_op = OR;
                10'b0000000_111: uop.alu_op = AND;
                default:         uop.illegal = 1'b1;
            endcase
        end

        if (uop.illegal) begin
            uop.rd = '0;
        end
    end

    // Source broke the credit rule if it writes a full buffer
    a_no_overflow: assert property (@(posedge clk_g) disable iff (!rst_n)
        !(fetch_in.valid && count == CNT_W'(`CORE_FETCH_DEPTH)));

endmodule

// File: hw/reg_file.sv
// Integer register file, two combinational reads and one write
// Register 0 is never written and always reads zero

`timescale 1ns/1ps

`include "core_config.svh"

module reg_file import core_pkg::*; (
    input  logic                  clk_g,
    input  logic                  rst_n,
    input  reg_idx_t              rd_addr_a,
    input  reg_idx_t              rd_addr_b,
    output logic [`CORE_XLEN-1:0] rd_data_a,
    output logic [`CORE_XLEN-1:0] rd_data_b,
    input  logic                  wr_en,
    input  reg_idx_t              wr_addr,
    input  logic [`CORE_XLEN-1:0] wr_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

    always_ff @(posedge clk_g or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

// File: hw/execute.sv
// Register read and execute stage
// Forwards only from its own result register, which is the single
// instruction in flight between decode and the register write
// A new uop is taken when the result register is empty or retiring now

`timescale 1ns/1ps

`include "core_config.svh"

module execute import core_pkg::*; (
    input  logic                  clk_g,
    input  logic                  rst_n,
    input  uop_t                  uop,
    input  logic                  uop_valid,
    output logic                  uop_take,
    output reg_idx_t              rd_addr_a,
    output reg_idx_t              rd_addr_b,
    input  logic [`CORE_XLEN-1:0] rd_data_a,
    input  logic [`CORE_XLEN-1:0] rd_data_b,
    output retire_t               result,
    input  logic                  ret_accept
);

    retire_t               res_q;
    logic                  fwd_ok;
    logic [`CORE_XLEN-1:0] src_a;
    logic [`CORE_XLEN-1:0] src_b;
    logic [`CORE_XLEN-1:0] alu_out;

    assign result   = res_q;
    assign uop_take = uop_valid & (~res_q.valid | ret_accept);

    // ========================================================================
    // Operand read and forwarding
    // ========================================================================

    assign rd_addr_a = uop.rs1;
    assign rd_addr_b = uop.rs2;

    // Result still waiting for its register write
    assign fwd_ok = res_q.valid & ~res_q.illegal & (res_q.rd != '0);

    always_comb begin
        src_a = rd_data_a;
        if (fwd_ok && res_q.rd == uop.rs1) begin
            src_a = res_q.value;
        end

        if (uop.use_imm) begin
            src_b = uop.imm;
        end else if (fwd_ok && res_q.rd == uop.rs2) begin
            src_b = res_q.value;
        end else begin
            src_b = rd_data_b;
        end
    end

    // ========================================================================
    // ALU
    // ========================================================================

    always_comb begin
        case (uop.alu_op)
            ADD:     alu_out = src_a + src_b;
            SUB:     alu_out = src_a - src_b;
            AND:     alu_out = src_a & src_b;
            OR:      alu_out = src_a | src_b;
            XOR:     alu_out = src_a ^ src_b;
            SLT:     alu_out = `CORE_XLEN'($signed(src_a) < $signed(src_b));
            SLTU:    alu_out = `CORE_XLEN'(src_a < src_b);
            default: alu_out = '0;
        endcase
        if (uop.illegal) begin
            alu_out = '0;
        end
    end

    // Result register
    always_ff @(posedge clk_g or negedge rst_n) begin
        if (!rst_n) begin
            res_q <= '0;
        end else if (uop_take) begin
            res_q.valid   <= 1'b1;
            res_q.pc      <= uop.pc;
            res_q.rd      <= uop.rd;
            res_q.value   <= alu_out;
            res_q.illegal <= uop.illegal;
        end else if (ret_accept) begin
            res_q.valid <= 1'b0;
        end
    end

endmodule

// File: hw/retire.sv
// Retire stage with credit-based output
// A record leaves in the same cycle it is accepted, so retire_out.valid
// is combinational from the result register and the credit count
// Illegal records are reported but write no register

`timescale 1ns/1ps

`include "core_config.svh"

module retire import core_pkg::*; (
    input  logic                  clk_g,
    input  logic                  rst_n,
    input  retire_t               result,
    output logic                  ret_accept,
    output logic                  wr_en,
    output reg_idx_t              wr_addr,
    output logic [`CORE_XLEN-1:0] wr_data,
    output retire_t               retire_out,
    input  logic                  retire_credit
);

    localparam int CNT_W = $clog2(`CORE_RET_CREDITS + 1);

    logic [CNT_W-1:0] credits;

    assign ret_accept = result.valid & (credits != '0);

    // Write-back
    assign wr_en   = ret_accept & ~result.illegal;
    assign wr_addr = result.rd;
    assign wr_data = result.value;

    always_comb begin
        retire_out       = result;
        retire_out.valid = ret_accept;
    end

    always_ff @(posedge clk_g or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CNT_W'(`CORE_RET_CREDITS);
        end else begin
            case ({retire_credit, ret_accept})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Sink returned more credits than it was given
    a_credit_bound: assert property (@(posedge clk_g) disable iff (!rst_n)
        credits <= CNT_W'(`CORE_RET_CREDITS));

endmodule

// File: hw/core_top.sv
// Top level of the integer core
// Both external ports use credit flow control, see fetch_decode and retire
// Only OP and OP-IMM ALU instructions execute; others retire as illegal

`timescale 1ns/1ps

`include "core_config.svh"

module core_top import core_pkg::*; (
    input  logic       clk_g,
    input  logic       rst_n,
    input  fetch_req_t fetch_in,
    output logic       fetch_credit,
    output retire_t    retire_out,
    input  logic       retire_credit
);

    uop_t                  uop;
    logic                  uop_valid;
    logic                  uop_take;
    reg_idx_t              rd_addr_a;
    reg_idx_t              rd_addr_b;
    logic [`CORE_XLEN-1:0] rd_data_a;
    logic [`CORE_XLEN-1:0] rd_data_b;
    retire_t               result;
    logic                  ret_accept;
    logic                  wr_en;
    reg_idx_t              wr_addr;
    logic [`CORE_XLEN-1:0] wr_data;

    // ========================================================================
    // Input side
    // ========================================================================

    fetch_decode i_fetch_decode (
        .clk_g        (clk_g),
        .rst_n        (rst_n),
        .fetch_in     (fetch_in),
        .fetch_credit (fetch_credit),
        .uop          (uop),
        .uop_valid    (uop_valid),
        .uop_take     (uop_take)
    );

    // ========================================================================
    // Execute and register file
    // ========================================================================

    execute i_execute (
        .clk_g      (clk_g),
        .rst_n      (rst_n),
        .uop        (uop),
        .uop_valid  (uop_valid),
        .uop_take   (uop_take),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .result     (result),
        .ret_accept (ret_accept)
    );

    reg_file i_reg_file (
        .clk_g     (clk_g),
        .rst_n     (rst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    // ========================================================================
    // Output side
    // ========================================================================

    retire i_retire (
        .clk_g         (clk_g),
        .rst_n         (rst_n),
        .result        (result),
        .ret_accept    (ret_accept),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .retire_out    (retire_out),
        .retire_credit (retire_credit)
    );

endmodule

// File: verification/core_tb.sv
// Testbench for the integer core top level
// Expected values in the table are worked out by hand from the RV32I rules
// The sink holds back its credits once to force back-pressure through the core
// Instructions are sent at pc = 4 * table index

`timescale 1ns/1ps

`include "core_config.svh"

module core_tb import core_pkg::*;;

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_ENTRIES  = 31;
    localparam int STALL_AT     = 12;
    localparam int STALL_CYCLES = 40;

    logic       clk_g = 1'b0;
    logic       rst_n;
    fetch_req_t fetch_in;
    logic       fetch_credit;
    retire_t    retire_out;
    logic       retire_credit;

    // Stimulus and expected results
    logic [31:0] tbl_word    [NUM_ENTRIES];
    logic [4:0]  tbl_rd      [NUM_ENTRIES];
    logic [31:0] tbl_value   [NUM_ENTRIES];
    logic        tbl_illegal [NUM_ENTRIES];
    int          fill_idx = 0;

    int     errors         = 0;
    int     rec_cnt        = 0;
    int     fetch_sent     = 0;
    int     fetch_returned = 0;
    int     given_back     = 0;
    int     peak_out       = 0;
    integer seed;

    core_top i_core_top (
        .clk_g         (clk_g),
        .rst_n         (rst_n),
        .fetch_in      (fetch_in),
        .fetch_credit  (fetch_credit),
        .retire_out    (retire_out),
        .retire_credit (retire_credit)
    );

    always #(CLK_PERIOD / 2) clk_g = ~clk_g;

    function automatic logic [31:0] imm_word(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] reg_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    task automatic add_entry(input logic [31:0] word, input logic [4:0] rd,
                             input logic [31:0] value, input logic illegal);
        tbl_word[fill_idx]    = word;
        tbl_rd[fill_idx]      = rd;
        tbl_value[fill_idx]   = value;
        tbl_illegal[fill_idx] = illegal;
        fill_idx++;
    endtask

    task automatic compare_field(input string name, input int idx,
                                 input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s record %0d: got %h expected %h", name, idx, got, exp);
            errors++;
        end
    endtask

    // ========================================================================
    // Instruction source spending one credit per valid cycle
    // ========================================================================

    initial begin : source
        fetch_in = '0;
        wait (rst_n === 1'b1);
        @(posedge clk_g);
        #1;
        for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
            while (fetch_sent - fetch_returned >= `CORE_FETCH_DEPTH) begin
                fetch_in = '0;
                @(posedge clk_g);
                #1;
            end
            fetch_in.valid = 1'b1;
            fetch_in.pc    = 32'(idx * 4);
            fetch_in.word  = tbl_word[idx];
            fetch_sent++;
            @(posedge clk_g);
            #1;
        end
        fetch_in = '0;
    end

    // Retire sink returning one credit per seen record after a random delay
    initial begin : sink
        int delay;
        retire_credit = 1'b0;
        seed = 80;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk_g);
            #1;
            if (rec_cnt > given_back) begin
                delay = int'($unsigned($random(seed)) % 4);
                if (given_back == STALL_AT) begin
                    delay = delay + STALL_CYCLES;
                end
                repeat (delay) begin
                    @(posedge clk_g);
                    #1;
                end
                retire_credit = 1'b1;
                @(posedge clk_g);
                #1;
                retire_credit = 1'b0;
                given_back++;
            end
        end
    end

    // ========================================================================
    // Checker sampling DUT outputs at the falling edge
    // ========================================================================

    always @(negedge clk_g) begin
        if (rst_n) begin
            if (fetch_credit) begin
                fetch_returned++;
                if (fetch_returned > fetch_sent) begin
                    $display("Instruction credit returned with nothing outstanding");
                    errors++;
                end
            end
            if (fetch_sent - fetch_returned > peak_out) begin
                peak_out = fetch_sent - fetch_returned;
            end
            if (retire_out.valid) begin
                if (rec_cnt >= NUM_ENTRIES) begin
                    $display("Retire record seen after the last instruction");
                    errors++;
                end else begin
                    compare_field("retire_out.pc", rec_cnt, retire_out.pc, 32'(rec_cnt * 4));
                    compare_field("retire_out.rd", rec_cnt, 32'(retire_out.rd),
                                  32'(tbl_rd[rec_cnt]));
                    compare_field("retire_out.value", rec_cnt, retire_out.value,
                                  tbl_value[rec_cnt]);
                    compare_field("retire_out.illegal", rec_cnt, 32'(retire_out.illegal),
                                  32'(tbl_illegal[rec_cnt]));
                end
                rec_cnt++;
                if (rec_cnt > given_back + `CORE_RET_CREDITS) begin
                    $display("Retire record sent without a retire credit");
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #(NUM_ENTRIES * 20 * CLK_PERIOD);
        $display("Timed out with %0d of %0d records retired", rec_cnt, NUM_ENTRIES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main
        rst_n = 1'b0;
        // Immediate ops, sign extension and compares
        add_entry(imm_word(3'd0, 5'd1, 5'd0, 12'd100), 5'd1, 32'h0000_0064, 1'b0);
        add_entry(imm_word(3'd0, 5'd2, 5'd0, 12'hFFB), 5'd2, 32'hFFFF_FFFB, 1'b0);
        add_entry(imm_word(3'd0, 5'd3, 5'd0, 12'h7FF), 5'd3, 32'h0000_07FF, 1'b0);
        add_entry(imm_word(3'd0, 5'd4, 5'd0, 12'h800), 5'd4, 32'hFFFF_F800, 1'b0);
        add_entry(imm_word(3'd7, 5'd5, 5'd1, 12'h00F), 5'd5, 32'h0000_0004, 1'b0);
        add_entry(imm_word(3'd6, 5'd6, 5'd1, 12'h103), 5'd6, 32'h0000_0167, 1'b0);
        add_entry(imm_word(3'd4, 5'd7, 5'd2, 12'hFFF), 5'd7, 32'h0000_0004, 1'b0);
        add_entry(imm_word(3'd2, 5'd8, 5'd2, 12'h000), 5'd8, 32'h0000_0001, 1'b0);
        add_entry(imm_word(3'd3, 5'd9, 5'd2, 12'h005), 5'd9, 32'h0000_0000, 1'b0);
        add_entry(imm_word(3'd3, 5'd10, 5'd1, 12'hFFF), 5'd10, 32'h0000_0001, 1'b0);
        // Register ops and a signed against unsigned compare of a negative value
        add_entry(reg_word(7'h00, 3'd0, 5'd11, 5'd1, 5'd2), 5'd11, 32'h0000_005F, 1'b0);
        add_entry(reg_word(7'h20, 3'd0, 5'd12, 5'd1, 5'd3), 5'd12, 32'hFFFF_F865, 1'b0);
        add_entry(reg_word(7'h00, 3'd7, 5'd13, 5'd2, 5'd3), 5'd13, 32'h0000_07FB, 1'b0);
        add_entry(reg_word(7'h00, 3'd6, 5'd14, 5'd1, 5'd4), 5'd14, 32'hFFFF_F864, 1'b0);
        add_entry(reg_word(7'h00, 3'd4, 5'd15, 5'd2, 5'd1), 5'd15, 32'hFFFF_FF9F, 1'b0);
        add_entry(reg_word(7'h00, 3'd2, 5'd16, 5'd2, 5'd1), 5'd16, 32'h0000_0001, 1'b0);
        add_entry(reg_word(7'h00, 3'd3, 5'd17, 5'd2, 5'd1), 5'd17, 32'h0000_0000, 1'b0);
        // Dependent chain through the result register
        add_entry(imm_word(3'd0, 5'd18, 5'd0, 12'd7), 5'd18, 32'h0000_0007, 1'b0);
        add_entry(reg_word(7'h00, 3'd0, 5'd18, 5'd18, 5'd18), 5'd18, 32'h0000_000E, 1'b0);
        add_entry(reg_word(7'h20, 3'd0, 5'd19, 5'd18, 5'd1), 5'd19, 32'hFFFF_FFAA, 1'b0);
        add_entry(reg_word(7'h00, 3'd4, 5'd20, 5'd19, 5'd18), 5'd20, 32'hFFFF_FFA4, 1'b0);
        add_entry(imm_word(3'd0, 5'd20, 5'd20, 12'd1), 5'd20, 32'hFFFF_FFA5, 1'b0);
        // x0 writes retire with a value while x0 still reads zero
        add_entry(imm_word(3'd0, 5'd0, 5'd1, 12'd5), 5'd0, 32'h0000_0069, 1'b0);
        add_entry(reg_word(7'h00, 3'd0, 5'd21, 5'd0, 5'd0), 5'd21, 32'h0000_0000, 1'b0);
        add_entry(reg_word(7'h00, 3'd0, 5'd22, 5'd0, 5'd1), 5'd22, 32'h0000_0064, 1'b0);
        // Unsupported encodings leave the registers untouched
        add_entry({7'h00, 5'd2, 5'd1, 3'd0, 5'd1, 7'h7F}, 5'd0, 32'h0000_0000, 1'b1);
        add_entry(imm_word(3'd1, 5'd23, 5'd1, 12'd3), 5'd0, 32'h0000_0000, 1'b1);
        add_entry(reg_word(7'h00, 3'd0, 5'd24, 5'd1, 5'd23), 5'd24, 32'h0000_0064, 1'b0);
        add_entry(reg_word(7'h01, 3'd0, 5'd26, 5'd1, 5'd1), 5'd0, 32'h0000_0000, 1'b1);
        add_entry(reg_word(7'h00, 3'd0, 5'd27, 5'd26, 5'd0), 5'd27, 32'h0000_0000, 1'b0);
        add_entry(reg_word(7'h20, 3'd0, 5'd28, 5'd2, 5'd4), 5'd28, 32'h0000_07FB, 1'b0);

        repeat (2) @(posedge clk_g);
        #1;
        rst_n = 1'b1;
        wait (rec_cnt == NUM_ENTRIES);
        repeat (10) @(posedge clk_g);
        if (peak_out < `CORE_FETCH_DEPTH) begin
            $display("Instruction buffer never filled while retire credits were held");
            errors++;
        end
        if (fetch_returned != fetch_sent) begin
            $display("FAILED fetch_credit pulses: got %h expected %h",
                     fetch_returned, fetch_sent);
            errors++;
        end
        $display("Errors: %0d, records retired: %0d of %0d", errors, rec_cnt, NUM_ENTRIES);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
hw/core_pkg.sv
hw/fetch_decode.sv
hw/reg_file.sv
hw/execute.sv
hw/retire.sv
hw/core_top.sv
verification/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := core_tb
FILELIST  := project.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := TESTBENCH FAILED
PASS_MSG  := TESTBENCH PASSED
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
